// ==== design/gat_pkg.sv ====
package gat_pkg;

  // Layer sizes
  localparam int NUM_FEAT_IN  = 16;
  localparam int NUM_FEAT_OUT = 4;
  localparam int MAX_NODES    = 4;

  // Element widths
  localparam int DATA_W     = 8;
  localparam int COL_W      = 4;
  localparam int WGT_ADDR_W = 7;
  localparam int WH_W       = 20;
  localparam int COEF_W     = 32;
  localparam int FEAT_W     = 32;
  localparam int NODE_W     = 2;
  localparam int FIDX_W     = $clog2(NUM_FEAT_OUT);

  // Weight store map: W row-major, then a_src, then a_nbr
  localparam int A_SRC_BASE = NUM_FEAT_IN * NUM_FEAT_OUT;
  localparam int A_NBR_BASE = A_SRC_BASE + NUM_FEAT_OUT;
  localparam int WGT_END    = A_NBR_BASE + NUM_FEAT_OUT;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic [COL_W-1:0]         col_t;
  typedef logic [WGT_ADDR_W-1:0]    wgt_addr_t;
  typedef logic signed [WH_W-1:0]   wh_t;
  typedef logic signed [COEF_W-1:0] coef_t;
  typedef logic signed [FEAT_W-1:0] feat_t;
  typedef logic [NODE_W-1:0]        node_t;

  // One WH row, elements keep the signed wh_t type
  typedef wh_t [NUM_FEAT_OUT-1:0] wh_row_t;

  typedef enum logic [1:0] {
    AGGR_IDLE,
    AGGR_MAC,
    AGGR_EMIT
  } aggr_state_e;

endpackage

// ==== design/weight_store.sv ====
`timescale 1ns/1ns

module weight_store
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wgt_we_i,
  input  wgt_addr_t wgt_addr_i,
  input  data_t     wgt_data_i,
  input  logic      wgt_load_done_i,
  output logic      w_rdy_o,
  output data_t     w_row_o [NUM_FEAT_IN][NUM_FEAT_OUT],
  output data_t     a_src_o [NUM_FEAT_OUT],
  output data_t     a_nbr_o [NUM_FEAT_OUT]
);

  logic [FIDX_W-1:0] col;
  col_t              row;

  // Low bits pick the output feature, the rest the input column
  assign col = wgt_addr_i[FIDX_W-1:0];
  assign row = wgt_addr_i[FIDX_W +: COL_W];

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      if (wgt_addr_i < WGT_ADDR_W'(A_SRC_BASE)) begin
        w_row_o[row][col] <= wgt_data_i;
      end else if (wgt_addr_i < WGT_ADDR_W'(A_NBR_BASE)) begin
        a_src_o[col] <= wgt_data_i;
      end else if (wgt_addr_i < WGT_ADDR_W'(WGT_END)) begin
        a_nbr_o[col] <= wgt_data_i;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_rdy_o <= 1'b0;
    end else if (wgt_load_done_i) begin
      w_rdy_o <= 1'b1;
    end
  end

endmodule

// ==== design/spmm.sv ====
`timescale 1ns/1ns

module spmm
  import gat_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    w_rdy_i,
  input  data_t   w_row_i [NUM_FEAT_IN][NUM_FEAT_OUT],
  input  logic    h_vld_i,
  input  col_t    h_col_i,
  input  data_t   h_val_i,
  input  logic    h_row_last_i,
  input  logic    h_graph_last_i,
  output logic    wh_vld_o,
  output wh_row_t wh_row_o,
  output node_t   wh_node_o,
  output logic    wh_graph_last_o
);

  logic    accept;
  logic    row_done;
  wh_row_t acc_q;
  wh_row_t sum;
  node_t   node_q;

  // Nonzeros are dropped until the weights are in
  assign accept   = h_vld_i && w_rdy_i;
  assign row_done = accept && h_row_last_i;

  // One nonzero times the selected W row, all outputs in parallel
  always_comb begin
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      sum[k] = $signed(acc_q[k]) + h_val_i * w_row_i[h_col_i][k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q           <= '0;
      node_q          <= '0;
      wh_vld_o        <= 1'b0;
      wh_node_o       <= '0;
      wh_graph_last_o <= 1'b0;
    end else begin
      wh_vld_o <= row_done;
      if (row_done) begin
        acc_q           <= '0;
        wh_node_o       <= node_q;
        wh_graph_last_o <= h_graph_last_i;
        // Node index restarts with the next subgraph
        if (h_graph_last_i) begin
          node_q <= '0;
        end else begin
          node_q <= node_q + 1'b1;
        end
      end else if (accept) begin
        acc_q <= sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_done) begin
      wh_row_o <= sum;
    end
  end

endmodule

// ==== design/dmvm.sv ====
`timescale 1ns/1ns

module dmvm
  import gat_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  data_t   a_src_i [NUM_FEAT_OUT],
  input  data_t   a_nbr_i [NUM_FEAT_OUT],
  input  logic    wh_vld_i,
  input  wh_row_t wh_row_i,
  input  node_t   wh_node_i,
  input  logic    wh_graph_last_i,
  output logic    coef_wr_o,
  output coef_t   coef_o,
  output logic    graph_done_o
);

  coef_t src_dot;
  coef_t nbr_dot;
  coef_t target_q;
  coef_t target;
  logic  is_target;
  logic  last_q;

  always_comb begin
    src_dot = '0;
    nbr_dot = '0;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      src_dot = src_dot + a_src_i[k] * $signed(wh_row_i[k]);
      nbr_dot = nbr_dot + a_nbr_i[k] * $signed(wh_row_i[k]);
    end
  end

  // The target's own term is not registered yet when node 0 arrives
  assign is_target = (wh_node_i == '0);
  assign target    = is_target ? src_dot : target_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_o    <= 1'b0;
      last_q       <= 1'b0;
      graph_done_o <= 1'b0;
    end else begin
      coef_wr_o    <= wh_vld_i;
      last_q       <= wh_vld_i && wh_graph_last_i;
      graph_done_o <= last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      coef_o <= target + nbr_dot;
      if (is_target) begin
        target_q <= src_dot;
      end
    end
  end

endmodule

// ==== design/coef_fifo.sv ====
`timescale 1ns/1ns

module coef_fifo
  import gat_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_i,
  input  coef_t din_i,
  input  logic  rd_i,
  output coef_t dout_o,
  output logic  empty_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  coef_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_rd;

  assign empty_o = (count == '0);
  assign do_rd   = rd_i && !empty_o;
  // Fall-through read
  assign dout_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_i && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !wr_i) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== design/aggregator.sv ====
`timescale 1ns/1ns

module aggregator
  import gat_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wh_vld_i,
  input  wh_row_t           wh_row_i,
  input  node_t             wh_node_i,
  input  logic              graph_done_i,
  input  coef_t             coef_i,
  input  logic              coef_empty_i,
  output logic              coef_rd_o,
  output logic              feat_vld_o,
  output logic [FIDX_W-1:0] feat_idx_o,
  output feat_t             feat_data_o,
  output logic              gat_ready_o
);

  aggr_state_e       state_q;
  wh_row_t           wh_mem [MAX_NODES];
  feat_t             acc_q [NUM_FEAT_OUT];
  node_t             last_node_q;
  node_t             mac_node_q;
  logic [FIDX_W-1:0] emit_idx_q;
  logic              start;

  assign start = (state_q == AGGR_IDLE) && graph_done_i;

  // WH rows of the current subgraph, by node index
  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      wh_mem[wh_node_i] <= wh_row_i;
    end
  end

  assign coef_rd_o   = (state_q == AGGR_MAC) && !coef_empty_i;
  assign feat_vld_o  = (state_q == AGGR_EMIT);
  assign feat_idx_o  = emit_idx_q;
  assign feat_data_o = acc_q[emit_idx_q];
  assign gat_ready_o = feat_vld_o && (emit_idx_q == FIDX_W'(NUM_FEAT_OUT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= AGGR_IDLE;
      last_node_q <= '0;
      mac_node_q  <= '0;
      emit_idx_q  <= '0;
    end else begin
      // Last row seen gives the node count
      if (wh_vld_i) begin
        last_node_q <= wh_node_i;
      end
      case (state_q)
        AGGR_IDLE: begin
          if (start) begin
            state_q    <= AGGR_MAC;
            mac_node_q <= '0;
          end
        end
        AGGR_MAC: begin
          if (coef_rd_o) begin
            mac_node_q <= mac_node_q + 1'b1;
            if (mac_node_q == last_node_q) begin
              state_q    <= AGGR_EMIT;
              emit_idx_q <= '0;
            end
          end
        end
        AGGR_EMIT: begin
          emit_idx_q <= emit_idx_q + 1'b1;
          if (gat_ready_o) begin
            state_q <= AGGR_IDLE;
          end
        end
        default: state_q <= AGGR_IDLE;
      endcase
    end
  end

  // One node per MAC cycle, products wrap in FEAT_W
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      if (start) begin
        acc_q[k] <= '0;
      end else if (coef_rd_o) begin
        acc_q[k] <= acc_q[k] + coef_i * $signed(wh_mem[mac_node_q][k]);
      end
    end
  end

endmodule

// ==== design/gat_conv.sv ====
`timescale 1ns/1ns

module gat_conv
  import gat_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wgt_we_i,
  input  wgt_addr_t         wgt_addr_i,
  input  data_t             wgt_data_i,
  input  logic              wgt_load_done_i,
  input  logic              h_vld_i,
  input  col_t              h_col_i,
  input  data_t             h_val_i,
  input  logic              h_row_last_i,
  input  logic              h_graph_last_i,
  output logic              feat_vld_o,
  output logic [FIDX_W-1:0] feat_idx_o,
  output feat_t             feat_data_o,
  output logic              gat_ready_o
);

  logic    w_rdy;
  data_t   w_row [NUM_FEAT_IN][NUM_FEAT_OUT];
  data_t   a_src [NUM_FEAT_OUT];
  data_t   a_nbr [NUM_FEAT_OUT];

  logic    wh_vld;
  wh_row_t wh_row;
  node_t   wh_node;
  logic    wh_graph_last;

  logic    coef_wr;
  coef_t   coef;
  logic    graph_done;
  logic    coef_rd;
  coef_t   coef_dout;
  logic    coef_empty;

  weight_store u_weight_store (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_we_i        (wgt_we_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_load_done_i (wgt_load_done_i),
    .w_rdy_o         (w_rdy),
    .w_row_o         (w_row),
    .a_src_o         (a_src),
    .a_nbr_o         (a_nbr)
  );

  spmm u_spmm (
    .clk             (clk),
    .rst_n           (rst_n),
    .w_rdy_i         (w_rdy),
    .w_row_i         (w_row),
    .h_vld_i         (h_vld_i),
    .h_col_i         (h_col_i),
    .h_val_i         (h_val_i),
    .h_row_last_i    (h_row_last_i),
    .h_graph_last_i  (h_graph_last_i),
    .wh_vld_o        (wh_vld),
    .wh_row_o        (wh_row),
    .wh_node_o       (wh_node),
    .wh_graph_last_o (wh_graph_last)
  );

  dmvm u_dmvm (
    .clk             (clk),
    .rst_n           (rst_n),
    .a_src_i         (a_src),
    .a_nbr_i         (a_nbr),
    .wh_vld_i        (wh_vld),
    .wh_row_i        (wh_row),
    .wh_node_i       (wh_node),
    .wh_graph_last_i (wh_graph_last),
    .coef_wr_o       (coef_wr),
    .coef_o          (coef),
    .graph_done_o    (graph_done)
  );

  // One entry per node of the largest subgraph
  coef_fifo #(
    .DEPTH (MAX_NODES)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef),
    .rd_i    (coef_rd),
    .dout_o  (coef_dout),
    .empty_o (coef_empty)
  );

  aggregator u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_vld_i     (wh_vld),
    .wh_row_i     (wh_row),
    .wh_node_i    (wh_node),
    .graph_done_i (graph_done),
    .coef_i       (coef_dout),
    .coef_empty_i (coef_empty),
    .coef_rd_o    (coef_rd),
    .feat_vld_o   (feat_vld_o),
    .feat_idx_o   (feat_idx_o),
    .feat_data_o  (feat_data_o),
    .gat_ready_o  (gat_ready_o)
  );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== bench/tb_gat_conv.sv ====
`timescale 1ns/1ns

module tb_gat_conv
  import gat_pkg::*;
();

  localparam int MAX_NZ    = 5;
  localparam int FEAT_WAIT = 100;
  // About four times the expected run length
  localparam int TIMEOUT_CYCLES = 2000;

  logic              clk;
  logic              rst_n;
  logic              wgt_we_i;
  wgt_addr_t         wgt_addr_i;
  data_t             wgt_data_i;
  logic              wgt_load_done_i;
  logic              h_vld_i;
  col_t              h_col_i;
  data_t             h_val_i;
  logic              h_row_last_i;
  logic              h_graph_last_i;
  logic              feat_vld_o;
  logic [FIDX_W-1:0] feat_idx_o;
  feat_t             feat_data_o;
  logic              gat_ready_o;

  // Reference copies of the weights and the current subgraph
  data_t w_ref [NUM_FEAT_IN][NUM_FEAT_OUT];
  data_t a_src_ref [NUM_FEAT_OUT];
  data_t a_nbr_ref [NUM_FEAT_OUT];
  int    num_nodes;
  int    nz_cnt [MAX_NODES];
  col_t  nz_col [MAX_NODES][MAX_NZ];
  data_t nz_val [MAX_NODES][MAX_NZ];
  feat_t exp_feat [NUM_FEAT_OUT];
  int    cycles = 0;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_conv u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_we_i        (wgt_we_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_load_done_i (wgt_load_done_i),
    .h_vld_i         (h_vld_i),
    .h_col_i         (h_col_i),
    .h_val_i         (h_val_i),
    .h_row_last_i    (h_row_last_i),
    .h_graph_last_i  (h_graph_last_i),
    .feat_vld_o      (feat_vld_o),
    .feat_idx_o      (feat_idx_o),
    .feat_data_o     (feat_data_o),
    .gat_ready_o     (gat_ready_o)
  );

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic check_feat(string name, feat_t got, feat_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(string name, logic [FIDX_W-1:0] got, logic [FIDX_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic write_weight(int addr, data_t val);
    @(posedge clk);
    wgt_we_i   <= 1'b1;
    wgt_addr_i <= wgt_addr_t'(addr);
    wgt_data_i <= val;
  endtask

  task automatic load_weights();
    for (int c = 0; c < NUM_FEAT_IN; c++) begin
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        write_weight(c * NUM_FEAT_OUT + k, w_ref[c][k]);
      end
    end
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      write_weight(A_SRC_BASE + k, a_src_ref[k]);
      write_weight(A_NBR_BASE + k, a_nbr_ref[k]);
    end
    @(posedge clk);
    wgt_we_i        <= 1'b0;
    wgt_load_done_i <= 1'b1;
    @(posedge clk);
    wgt_load_done_i <= 1'b0;
  endtask

  task automatic send_subgraph();
    for (int j = 0; j < num_nodes; j++) begin
      for (int e = 0; e < nz_cnt[j]; e++) begin
        @(posedge clk);
        h_vld_i        <= 1'b1;
        h_col_i        <= nz_col[j][e];
        h_val_i        <= nz_val[j][e];
        h_row_last_i   <= (e == nz_cnt[j] - 1);
        h_graph_last_i <= (j == num_nodes - 1) && (e == nz_cnt[j] - 1);
      end
    end
    @(posedge clk);
    h_vld_i        <= 1'b0;
    h_row_last_i   <= 1'b0;
    h_graph_last_i <= 1'b0;
  endtask

  // WH, then target plus neighbour terms, then coefficient-weighted sums
  function automatic void compute_expected();
    wh_t    wh [MAX_NODES][NUM_FEAT_OUT];
    coef_t  coef [MAX_NODES];
    longint sum;
    longint target;
    feat_t  acc;
    target = 0;
    for (int j = 0; j < num_nodes; j++) begin
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        sum = 0;
        for (int e = 0; e < nz_cnt[j]; e++) begin
          sum += longint'(nz_val[j][e]) * longint'(w_ref[nz_col[j][e]][k]);
        end
        wh[j][k] = wh_t'(sum);
      end
    end
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      target += longint'(a_src_ref[k]) * longint'(wh[0][k]);
    end
    for (int j = 0; j < num_nodes; j++) begin
      sum = target;
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        sum += longint'(a_nbr_ref[k]) * longint'(wh[j][k]);
      end
      coef[j] = coef_t'(sum);
    end
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      acc = '0;
      for (int j = 0; j < num_nodes; j++) begin
        acc = feat_t'(longint'(acc) + longint'(coef[j]) * longint'(wh[j][k]));
      end
      exp_feat[k] = acc;
    end
  endfunction

  task automatic collect_features();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!feat_vld_o) begin
      if (waited == FEAT_WAIT) begin
        $display("No feature output within %0d cycles after the subgraph", FEAT_WAIT);
        abort_run();
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      if (k > 0) begin
        @(negedge clk);
        check_flag("feat_vld_o", feat_vld_o, 1'b1);
      end
      check_idx("feat_idx_o", feat_idx_o, FIDX_W'(k));
      check_feat("feat_data_o", feat_data_o, exp_feat[k]);
      check_flag("gat_ready_o", gat_ready_o, k == NUM_FEAT_OUT - 1);
    end
  endtask

  task automatic run_subgraph();
    compute_expected();
    send_subgraph();
    collect_features();
  endtask

  function automatic void random_subgraph(int nodes);
    num_nodes = nodes;
    for (int j = 0; j < nodes; j++) begin
      nz_cnt[j] = 1 + int'($urandom % MAX_NZ);
      for (int e = 0; e < nz_cnt[j]; e++) begin
        nz_col[j][e] = col_t'($urandom);
        nz_val[j][e] = data_t'($urandom);
      end
    end
  endfunction

  function automatic void set_node(int j, int cnt, int c0, int v0, int c1, int v1);
    nz_cnt[j]    = cnt;
    nz_col[j][0] = col_t'(c0);
    nz_val[j][0] = data_t'(v0);
    nz_col[j][1] = col_t'(c1);
    nz_val[j][1] = data_t'(v1);
  endfunction

  task automatic test_no_output_before_weights();
    num_nodes = 2;
    set_node(0, 2, 1, 20, 6, -9);
    set_node(1, 1, 4, 33, 0, 0);
    send_subgraph();
    repeat (20) begin
      @(negedge clk);
      check_flag("feat_vld_o", feat_vld_o, 1'b0);
    end
  endtask

  task automatic test_single_node();
    for (int c = 0; c < NUM_FEAT_IN; c++) begin
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        w_ref[c][k] = data_t'((c * 7 + k * 3) % 11 - 5);
      end
    end
    a_src_ref = '{8'sd1, -8'sd2, 8'sd3, -8'sd1};
    a_nbr_ref = '{8'sd2, 8'sd1, -8'sd1, 8'sd1};
    load_weights();
    num_nodes = 1;
    set_node(0, 2, 3, 5, 15, -7);
    run_subgraph();
  endtask

  // Target term must come from node 0 only
  task automatic test_three_nodes();
    num_nodes = 3;
    set_node(0, 2, 0, 4, 5, -3);
    set_node(1, 1, 2, 9, 0, 0);
    set_node(2, 2, 8, 6, 12, -2);
    run_subgraph();
  endtask

  task automatic test_random_subgraphs();
    for (int c = 0; c < NUM_FEAT_IN; c++) begin
      for (int k = 0; k < NUM_FEAT_OUT; k++) begin
        w_ref[c][k] = data_t'($urandom);
      end
    end
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      a_src_ref[k] = data_t'($urandom);
      a_nbr_ref[k] = data_t'($urandom);
    end
    load_weights();
    repeat (10) begin
      random_subgraph(1 + int'($urandom % MAX_NODES));
      run_subgraph();
    end
  endtask

  // A full subgraph followed by smaller ones
  task automatic test_consecutive();
    int sizes [4];
    sizes = '{4, 1, 3, 2};
    foreach (sizes[i]) begin
      random_subgraph(sizes[i]);
      run_subgraph();
    end
  endtask

  initial begin
    void'($urandom(32'h1225_312b));
    wgt_we_i        = 1'b0;
    wgt_addr_i      = '0;
    wgt_data_i      = '0;
    wgt_load_done_i = 1'b0;
    h_vld_i         = 1'b0;
    h_col_i         = '0;
    h_val_i         = '0;
    h_row_last_i    = 1'b0;
    h_graph_last_i  = 1'b0;
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    test_no_output_before_weights();
    test_single_node();
    test_three_nodes();
    test_random_subgraphs();
    test_consecutive();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/gat_pkg.sv
design/weight_store.sv
design/spmm.sv
design/dmvm.sv
design/coef_fifo.sv
design/aggregator.sv
design/gat_conv.sv
bench/clk_gen.sv
bench/tb_gat_conv.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_gat_conv -f verilog.f -o tb_gat_conv
./obj_dir/tb_gat_conv 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
grep -q "sim passed" sim.log
